// File: manycore_pkg.sv
// shared definitions for the manycore remote-access endpoint
// address widths, coordinate types, EVA field positions,
// request/packet structs and the AXI4-Lite config bus
`default_nettype none

package manycore_pkg;

  localparam int eva_width_gp    = 32;
  localparam int epa_width_gp    = 28;  // word address, msb = host dram
  localparam int x_cord_width_gp = 4;
  localparam int y_cord_width_gp = 3;
  localparam int data_width_gp   = 32;
  localparam int cnt_width_gp    = 16;
  localparam int axil_addr_width_gp = 32;

  typedef logic [eva_width_gp-1:0]       eva_t;  // byte addr
  typedef logic [epa_width_gp-1:0]       epa_t;
  typedef logic [x_cord_width_gp-1:0]    x_cord_t;
  typedef logic [y_cord_width_gp-1:0]    y_cord_t;  // '1 = bottom row
  typedef logic [data_width_gp-1:0]      data_t;
  typedef logic [data_width_gp/8-1:0]    mask_t;
  typedef logic [cnt_width_gp-1:0]       cnt_t;
  typedef logic [axil_addr_width_gp-1:0] axil_addr_t;

  // remote tags, taken from the top of the EVA
  localparam logic [1:0] remote_global_gp     = 2'b01;
  localparam logic [2:0] remote_tile_group_gp = 3'b001;

  // field positions, shared by global and tile-group EVAs
  localparam int global_y_lsb_gp        = 24;
  localparam int global_x_lsb_gp        = 18;
  localparam int epa_word_addr_width_gp = 16;  // eva[17:2]

  // config register offsets
  localparam axil_addr_t csr_ctrl_gp        = 32'h0;  // bit 0 dram enable
  localparam axil_addr_t csr_tgo_gp         = 32'h4;  // x 3:0, y 10:8
  localparam axil_addr_t csr_invalid_cnt_gp = 32'h8;  // ro, write clears

  localparam logic [1:0] axil_resp_okay_gp   = 2'b00;
  localparam logic [1:0] axil_resp_slverr_gp = 2'b10;

  typedef struct packed {
    logic  write;
    eva_t  eva;
    data_t data;
    mask_t mask;
  } core_req_s;

  typedef struct packed {
    x_cord_t x_cord;
    y_cord_t y_cord;
    epa_t    epa;
    logic    write;
    data_t   data;
    mask_t   mask;
  } net_pkt_s;

  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    data_t      wdata;
    mask_t      wstrb;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_s;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       arready;
    data_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
  } axil_rsp_s;

endpackage

`default_nettype wire

// File: bank_hash.sv
// vcache bank hash
// xor-folds a dram block address into a bank number so strided
// accesses spread over all banks; the index is the line position
// inside the chosen bank
`timescale 1ns/1ps
`default_nettype none

module bank_hash #(
  parameter int banks_p = 8,
  parameter int width_p = 26
) (
  input  logic [width_p-1:0]                  addr_i,
  output logic [$clog2(banks_p)-1:0]          bank_o,
  output logic [width_p-$clog2(banks_p)-1:0]  index_o
);

  localparam int lg_banks_lp  = $clog2(banks_p);
  localparam int groups_lp    = (width_p + lg_banks_lp - 1) / lg_banks_lp;
  localparam int pad_width_lp = groups_lp * lg_banks_lp;

  logic [pad_width_lp-1:0] addr_pad;

  assign addr_pad = pad_width_lp'(addr_i);  // top group zero padded

  always_comb begin
    bank_o = '0;
    for (int i = 0; i < groups_lp; i++) begin
      bank_o = bank_o ^ addr_pad[i*lg_banks_lp +: lg_banks_lp];
    end
  end

  assign index_o = addr_i[width_p-1:lg_banks_lp];  // drop bank bits

endmodule

`default_nettype wire

// File: eva_to_npa.sv
// EVA to network physical address translation
// classifies a core byte address as dram, global or tile-group
// and produces the destination x/y and the word-granular EPA.
// dram goes to a vcache on the top/bottom row (hashed or direct)
// or to host dram when dram mode is off
`timescale 1ns/1ps
`default_nettype none

module eva_to_npa #(
  parameter int num_tiles_x_p                = 4,
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_size_p                = 512
) (
  input  manycore_pkg::eva_t    eva_i,
  input  logic                  dram_enable_i,
  input  manycore_pkg::x_cord_t tgo_x_i,
  input  manycore_pkg::y_cord_t tgo_y_i,
  output manycore_pkg::x_cord_t x_cord_o,
  output manycore_pkg::y_cord_t y_cord_o,
  output manycore_pkg::epa_t    epa_o,
  output logic                  is_invalid_addr_o
);

  localparam int word_offset_width_lp = $clog2(vcache_block_size_in_words_p);
  localparam int lg_vcache_size_lp    = $clog2(vcache_size_p);
  localparam int lg_tiles_x_lp        = $clog2(num_tiles_x_p);
  localparam int banks_lp             = 2 * num_tiles_x_p;
  localparam int lg_banks_lp          = $clog2(banks_lp);
  localparam int hash_width_lp  = manycore_pkg::eva_width_gp - 3 - word_offset_width_lp;
  localparam int dm_x_lsb_lp    = 2 + lg_vcache_size_lp;  // above vcache word range

  logic is_dram;
  logic is_global;
  logic is_tile_group;
  logic [lg_banks_lp-1:0]               hash_bank;
  logic [hash_width_lp-lg_banks_lp-1:0] hash_index;
  manycore_pkg::x_cord_t                field_x;
  manycore_pkg::y_cord_t                field_y;
  manycore_pkg::epa_t                   word_epa;

  assign is_dram       = eva_i[31];
  assign is_global     = eva_i[31 -: 2] == manycore_pkg::remote_global_gp;
  assign is_tile_group = eva_i[31 -: 3] == manycore_pkg::remote_tile_group_gp;
  assign is_invalid_addr_o = ~(is_dram | is_global | is_tile_group);

  assign field_x  = eva_i[manycore_pkg::global_x_lsb_gp +: manycore_pkg::x_cord_width_gp];
  assign field_y  = eva_i[manycore_pkg::global_y_lsb_gp +: manycore_pkg::y_cord_width_gp];
  assign word_epa = manycore_pkg::epa_t'(eva_i[2 +: manycore_pkg::epa_word_addr_width_gp]);

  // block address = eva[30 : word offset + 2]
  bank_hash #(
    .banks_p(banks_lp),
    .width_p(hash_width_lp)
  ) bank_hash_inst (
    .addr_i (eva_i[2+word_offset_width_lp +: hash_width_lp]),
    .bank_o (hash_bank),
    .index_o(hash_index)
  );

  always_comb begin
    x_cord_o = '0;
    y_cord_o = '0;
    epa_o    = '0;
    if (is_dram) begin
      if (dram_enable_i) begin
        y_cord_o = hash_bank[lg_banks_lp-1] ? '1 : '0;  // msb picks bottom row
        x_cord_o = manycore_pkg::x_cord_t'(hash_bank[lg_banks_lp-2:0]);
        epa_o    = manycore_pkg::epa_t'({hash_index, eva_i[2 +: word_offset_width_lp]});
      end else if (eva_i[30]) begin
        epa_o = {1'b1, eva_i[2 +: manycore_pkg::epa_width_gp-1]};  // host dram at (0,0)
      end else begin
        // direct mapped: x above the vcache range, then the row bit
        y_cord_o = eva_i[dm_x_lsb_lp+lg_tiles_x_lp] ? '1 : '0;
        x_cord_o = manycore_pkg::x_cord_t'(eva_i[dm_x_lsb_lp +: lg_tiles_x_lp]);
        epa_o    = manycore_pkg::epa_t'(eva_i[2 +: lg_vcache_size_lp]);
      end
    end else if (is_global) begin
      x_cord_o = field_x;
      y_cord_o = field_y;
      epa_o    = word_epa;
    end else if (is_tile_group) begin
      x_cord_o = field_x + tgo_x_i;  // wraps at field width
      y_cord_o = field_y + tgo_y_i;
      epa_o    = word_epa;
    end
  end

  // exactly one address class per request
  always_comb begin
    assert ($onehot({is_dram, is_global, is_tile_group, is_invalid_addr_o}))
      else $error("eva_to_npa: address class not unique");
  end

endmodule

`default_nettype wire

// File: endpoint_cfg_regs.sv
// endpoint configuration registers on AXI4-Lite
// dram enable, tile-group origin and the invalid-request counter
// readback; a write to the counter offset pulses a clear
`timescale 1ns/1ps
`default_nettype none

module endpoint_cfg_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  manycore_pkg::axil_req_s axil_req_i,
  output manycore_pkg::axil_rsp_s axil_rsp_o,
  input  manycore_pkg::cnt_t      invalid_cnt_i,
  output logic                    dram_enable_o,
  output manycore_pkg::x_cord_t   tgo_x_o,
  output manycore_pkg::y_cord_t   tgo_y_o,
  output logic                    cnt_clear_o
);

  logic               wr_hs;
  logic               rd_hs;
  logic               wr_mapped;
  logic               bvalid_r;
  logic               rvalid_r;
  logic [1:0]         bresp_r;
  logic [1:0]         rresp_r;
  manycore_pkg::data_t rdata_r;
  manycore_pkg::data_t rd_mux;
  logic               rd_mapped;

  // aw and w taken together with one response outstanding at a time
  assign wr_hs = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_r;
  assign rd_hs = axil_req_i.arvalid & ~rvalid_r;

  assign wr_mapped = axil_req_i.awaddr == manycore_pkg::csr_ctrl_gp
                   | axil_req_i.awaddr == manycore_pkg::csr_tgo_gp
                   | axil_req_i.awaddr == manycore_pkg::csr_invalid_cnt_gp;

  always_comb begin
    rd_mux    = '0;
    rd_mapped = 1'b1;
    case (axil_req_i.araddr)
      manycore_pkg::csr_ctrl_gp:        rd_mux[0] = dram_enable_o;
      manycore_pkg::csr_tgo_gp:         rd_mux = {21'b0, tgo_y_o, 4'b0, tgo_x_o};
      manycore_pkg::csr_invalid_cnt_gp: rd_mux[15:0] = invalid_cnt_i;
      default:                          rd_mapped = 1'b0;  // reads as zero
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bvalid_r      <= 1'b0;
      rvalid_r      <= 1'b0;
      dram_enable_o <= 1'b0;
      tgo_x_o       <= '0;
      tgo_y_o       <= '0;
      cnt_clear_o   <= 1'b0;
    end else begin
      cnt_clear_o <= wr_hs && axil_req_i.awaddr == manycore_pkg::csr_invalid_cnt_gp;
      if (wr_hs) begin
        bvalid_r <= 1'b1;
        if (axil_req_i.awaddr == manycore_pkg::csr_ctrl_gp && axil_req_i.wstrb[0])
          dram_enable_o <= axil_req_i.wdata[0];
        if (axil_req_i.awaddr == manycore_pkg::csr_tgo_gp) begin
          if (axil_req_i.wstrb[0]) tgo_x_o <= axil_req_i.wdata[3:0];
          if (axil_req_i.wstrb[1]) tgo_y_o <= axil_req_i.wdata[10:8];
        end
      end else if (axil_req_i.bready) begin
        bvalid_r <= 1'b0;
      end
      if (rd_hs) rvalid_r <= 1'b1;
      else if (axil_req_i.rready) rvalid_r <= 1'b0;
    end
  end

  // response payload loaded at each handshake
  always_ff @(posedge clk_i) begin
    if (wr_hs) bresp_r <= wr_mapped ? manycore_pkg::axil_resp_okay_gp
                                    : manycore_pkg::axil_resp_slverr_gp;
    if (rd_hs) begin
      rdata_r <= rd_mux;
      rresp_r <= rd_mapped ? manycore_pkg::axil_resp_okay_gp
                           : manycore_pkg::axil_resp_slverr_gp;
    end
  end

  assign axil_rsp_o.awready = wr_hs;
  assign axil_rsp_o.wready  = wr_hs;
  assign axil_rsp_o.bresp   = bresp_r;
  assign axil_rsp_o.bvalid  = bvalid_r;
  assign axil_rsp_o.arready = rd_hs;
  assign axil_rsp_o.rdata   = rdata_r;
  assign axil_rsp_o.rresp   = rresp_r;
  assign axil_rsp_o.rvalid  = rvalid_r;

  // a write response only follows an accepted aw/w pair
  assert property (@(posedge clk_i) disable iff (rst_i) $rose(bvalid_r) |-> $past(wr_hs))
    else $error("endpoint_cfg_regs: bvalid without write handshake");

endmodule

`default_nettype wire

// File: remote_req_gen.sv
// remote request stage
// translates accepted core requests and holds the resulting packet
// in one output register until the network takes it; requests to
// invalid addresses are swallowed and counted
`timescale 1ns/1ps
`default_nettype none

module remote_req_gen #(
  parameter int num_tiles_x_p                = 4,
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_size_p                = 512
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  manycore_pkg::core_req_s core_req_i,
  input  logic                    core_v_i,
  output logic                    core_ready_o,
  input  logic                    dram_enable_i,
  input  manycore_pkg::x_cord_t   tgo_x_i,
  input  manycore_pkg::y_cord_t   tgo_y_i,
  input  logic                    cnt_clear_i,
  output manycore_pkg::net_pkt_s  pkt_o,
  output logic                    pkt_v_o,
  input  logic                    pkt_ready_i,
  output manycore_pkg::cnt_t      invalid_cnt_o
);

  manycore_pkg::x_cord_t x_cord;
  manycore_pkg::y_cord_t y_cord;
  manycore_pkg::epa_t    epa;
  logic                  is_invalid;
  logic                  accept;
  logic                  bump;

  eva_to_npa #(
    .num_tiles_x_p               (num_tiles_x_p),
    .vcache_block_size_in_words_p(vcache_block_size_in_words_p),
    .vcache_size_p               (vcache_size_p)
  ) eva_to_npa_inst (
    .eva_i            (core_req_i.eva),
    .dram_enable_i    (dram_enable_i),
    .tgo_x_i          (tgo_x_i),
    .tgo_y_i          (tgo_y_i),
    .x_cord_o         (x_cord),
    .y_cord_o         (y_cord),
    .epa_o            (epa),
    .is_invalid_addr_o(is_invalid)
  );

  assign core_ready_o = ~pkt_v_o | pkt_ready_i;  // empty or draining
  assign accept       = core_v_i & core_ready_o;
  assign bump         = accept & is_invalid;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pkt_v_o <= 1'b0;
    end else if (accept) begin
      pkt_v_o <= ~is_invalid;
    end else if (pkt_ready_i) begin
      pkt_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !is_invalid) begin
      pkt_o.x_cord <= x_cord;
      pkt_o.y_cord <= y_cord;
      pkt_o.epa    <= epa;
      pkt_o.write  <= core_req_i.write;
      pkt_o.data   <= core_req_i.data;
      pkt_o.mask   <= core_req_i.mask;
    end
  end

  // saturating count, clear wins but keeps a same-cycle increment
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      invalid_cnt_o <= '0;
    end else if (cnt_clear_i) begin
      invalid_cnt_o <= manycore_pkg::cnt_t'(bump);
    end else if (bump && invalid_cnt_o != '1) begin
      invalid_cnt_o <= invalid_cnt_o + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_v_o && !pkt_ready_i |=> pkt_v_o && $stable(pkt_o))
    else $error("remote_req_gen: packet changed under back-pressure");

endmodule

`default_nettype wire

// File: manycore_endpoint_top.sv
// manycore tile remote-access endpoint
// config registers on AXI4-Lite plus the request stage that turns
// core loads/stores into mesh packets
`timescale 1ns/1ps
`default_nettype none

module manycore_endpoint_top #(
  parameter int num_tiles_x_p                = 4,  // power of two
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_size_p                = 512  // words
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  manycore_pkg::axil_req_s axil_req_i,
  output manycore_pkg::axil_rsp_s axil_rsp_o,
  input  manycore_pkg::core_req_s core_req_i,
  input  logic                    core_v_i,
  output logic                    core_ready_o,
  output manycore_pkg::net_pkt_s  pkt_o,
  output logic                    pkt_v_o,
  input  logic                    pkt_ready_i
);

  logic                  dram_enable;
  manycore_pkg::x_cord_t tgo_x;
  manycore_pkg::y_cord_t tgo_y;
  logic                  cnt_clear;
  manycore_pkg::cnt_t    invalid_cnt;

  endpoint_cfg_regs endpoint_cfg_regs_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (axil_rsp_o),
    .invalid_cnt_i(invalid_cnt),
    .dram_enable_o(dram_enable),
    .tgo_x_o      (tgo_x),
    .tgo_y_o      (tgo_y),
    .cnt_clear_o  (cnt_clear)
  );

  remote_req_gen #(
    .num_tiles_x_p               (num_tiles_x_p),
    .vcache_block_size_in_words_p(vcache_block_size_in_words_p),
    .vcache_size_p               (vcache_size_p)
  ) remote_req_gen_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_req_i   (core_req_i),
    .core_v_i     (core_v_i),
    .core_ready_o (core_ready_o),
    .dram_enable_i(dram_enable),
    .tgo_x_i      (tgo_x),
    .tgo_y_i      (tgo_y),
    .cnt_clear_i  (cnt_clear),
    .pkt_o        (pkt_o),
    .pkt_v_o      (pkt_v_o),
    .pkt_ready_i  (pkt_ready_i),
    .invalid_cnt_o(invalid_cnt)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock source
// free-running clock, low at time zero
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_p = 8  // ns
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: tb_manycore_endpoint.sv
// testbench for the manycore remote-access endpoint
// directed tests over the AXI4-Lite config port and the core port,
// a reference translation model and an in-order packet scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_manycore_endpoint;

  localparam int tiles_x_lp     = 4;
  localparam int block_words_lp = 8;
  localparam int vcache_size_lp = 512;
  localparam int timeout_lp     = 5000;  // whole run needs well under 1000 cycles

  localparam int off_bits_lp  = $clog2(block_words_lp);  // word in block
  localparam int vc_bits_lp   = $clog2(vcache_size_lp);
  localparam int tx_bits_lp   = $clog2(tiles_x_lp);
  localparam int bank_bits_lp = $clog2(2 * tiles_x_lp);
  localparam int blk_bits_lp  = 29 - off_bits_lp;  // eva[30 : off+2]

  localparam logic [1:0] okay_lp   = 2'b00;
  localparam logic [1:0] slverr_lp = 2'b10;

  logic                    clk;
  logic                    rst;
  manycore_pkg::axil_req_s axil_req;
  manycore_pkg::axil_rsp_s axil_rsp;
  manycore_pkg::core_req_s core_req;
  logic                    core_v;
  logic                    core_ready;
  manycore_pkg::net_pkt_s  pkt;
  logic                    pkt_v;
  logic                    pkt_ready;

  manycore_pkg::net_pkt_s exp_q[$];  // scoreboard
  manycore_pkg::net_pkt_s exp_pkt;
  manycore_pkg::net_pkt_s held_pkt;
  logic                   held_v;
  int                     errors;
  int                     pkt_checked;
  int                     cycles;
  string                  test_name;
  logic [31:0]            lcg_state;
  logic                   mdl_dram_en;  // model view of the config regs
  manycore_pkg::x_cord_t  mdl_tgo_x;
  manycore_pkg::y_cord_t  mdl_tgo_y;

  tb_clk_gen #(.period_p(8)) tb_clk_gen_inst (.clk_o(clk));

  manycore_endpoint_top #(
    .num_tiles_x_p               (tiles_x_lp),
    .vcache_block_size_in_words_p(block_words_lp),
    .vcache_size_p               (vcache_size_lp)
  ) manycore_endpoint_top_inst (
    .clk_i       (clk),
    .rst_i       (rst),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .core_req_i  (core_req),
    .core_v_i    (core_v),
    .core_ready_o(core_ready),
    .pkt_o       (pkt),
    .pkt_v_o     (pkt_v),
    .pkt_ready_i (pkt_ready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic manycore_pkg::core_req_s rand_req(input manycore_pkg::eva_t eva);
    manycore_pkg::core_req_s r;
    logic [31:0] rnd;
    rnd    = lcg_next();
    r.write = rnd[31];
    r.mask  = rnd[19:16];
    r.data  = lcg_next();
    r.eva   = eva;
    return r;
  endfunction

  function automatic manycore_pkg::net_pkt_s make_pkt(input manycore_pkg::core_req_s req,
      input manycore_pkg::x_cord_t x, input manycore_pkg::y_cord_t y,
      input manycore_pkg::epa_t epa);
    manycore_pkg::net_pkt_s p;
    p.x_cord = x;
    p.y_cord = y;
    p.epa    = epa;
    p.write  = req.write;
    p.data   = req.data;
    p.mask   = req.mask;
    return p;
  endfunction

  // reference translation that returns 0 for an invalid address
  function automatic logic ref_translate(input manycore_pkg::core_req_s req,
      output manycore_pkg::net_pkt_s p);
    manycore_pkg::eva_t     eva;
    logic [blk_bits_lp-1:0] blk;
    logic [bank_bits_lp-1:0] bank;
    eva = req.eva;
    blk = eva[30:2+off_bits_lp];
    bank = '0;
    p = '0;
    if (eva[31] && mdl_dram_en) begin
      for (int i = 0; i < blk_bits_lp; i += bank_bits_lp) begin
        bank = bank ^ bank_bits_lp'(blk >> i);  // xor fold with the top group zero filled
      end
      p = make_pkt(req, 4'(bank[bank_bits_lp-2:0]), bank[bank_bits_lp-1] ? 3'b111 : 3'b000,
                   28'({blk >> bank_bits_lp, eva[2 +: off_bits_lp]}));
    end else if (eva[31] && eva[30]) begin
      p = make_pkt(req, 4'd0, 3'd0, {1'b1, eva[28:2]});  // host dram
    end else if (eva[31]) begin
      p = make_pkt(req, 4'(eva[2+vc_bits_lp +: tx_bits_lp]),
                   eva[2+vc_bits_lp+tx_bits_lp] ? 3'b111 : 3'b000,
                   28'(eva[2 +: vc_bits_lp]));
    end else if (eva[31:30] == 2'b01) begin
      p = make_pkt(req, eva[21:18], eva[26:24], 28'(eva[17:2]));
    end else if (eva[31:29] == 3'b001) begin
      p = make_pkt(req, eva[21:18] + mdl_tgo_x, eva[26:24] + mdl_tgo_y, 28'(eva[17:2]));
    end else begin
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // all tasks start and end 1 ns after a rising edge
  task automatic axil_write(input manycore_pkg::axil_addr_t addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) @(negedge clk);
    check_val("wready", 32'h1, 32'(axil_rsp.wready));
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    check_val("bresp", 32'(exp_resp), 32'(axil_rsp.bresp));
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read_check(input manycore_pkg::axil_addr_t addr,
                                 input logic [31:0] exp_data, input logic [1:0] exp_resp);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    check_val("rdata", exp_data, axil_rsp.rdata);
    check_val("rresp", 32'(exp_resp), 32'(axil_rsp.rresp));
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic set_config(input logic en, input logic [3:0] x, input logic [2:0] y);
    axil_write(manycore_pkg::csr_ctrl_gp, {31'b0, en}, 4'hf, okay_lp);
    axil_write(manycore_pkg::csr_tgo_gp, {21'b0, y, 4'b0, x}, 4'hf, okay_lp);
    mdl_dram_en = en;
    mdl_tgo_x   = x;
    mdl_tgo_y   = y;
  endtask

  task automatic send_req(input manycore_pkg::core_req_s req, input logic has_pkt,
                          input manycore_pkg::net_pkt_s p);
    core_req = req;
    core_v   = 1'b1;
    @(negedge clk);
    while (!core_ready) @(negedge clk);
    if (has_pkt) exp_q.push_back(p);  // accepted at the coming edge
    @(posedge clk);
    #1;
    core_v = 1'b0;
  endtask

  task automatic send_rand(input manycore_pkg::eva_t base, input manycore_pkg::eva_t keep,
                           input int n);
    manycore_pkg::core_req_s req;
    manycore_pkg::net_pkt_s  p;
    logic                    ok;
    for (int i = 0; i < n; i++) begin
      req = rand_req(base | (lcg_next() & keep));
      ok  = ref_translate(req, p);
      send_req(req, ok, p);
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic test_registers();
    test_name = "registers";
    axil_write(manycore_pkg::csr_ctrl_gp, 32'h1, 4'hf, okay_lp);
    axil_read_check(manycore_pkg::csr_ctrl_gp, 32'h1, okay_lp);
    axil_write(manycore_pkg::csr_tgo_gp, 32'h0000_0509, 4'hf, okay_lp);
    axil_read_check(manycore_pkg::csr_tgo_gp, 32'h509, okay_lp);
    // only byte 0 written so y keeps 5
    axil_write(manycore_pkg::csr_tgo_gp, 32'h0000_0703, 4'h1, okay_lp);
    axil_read_check(manycore_pkg::csr_tgo_gp, 32'h503, okay_lp);
    axil_write(32'hc, 32'hffff_ffff, 4'hf, slverr_lp);
    axil_read_check(32'hc, 32'h0, slverr_lp);
    axil_write(manycore_pkg::csr_ctrl_gp, 32'h0, 4'hf, okay_lp);
    axil_read_check(manycore_pkg::csr_ctrl_gp, 32'h0, okay_lp);
  endtask

  task automatic test_remote();
    manycore_pkg::core_req_s req;
    test_name = "global_tile_group";
    set_config(1'b0, 4'd13, 3'd6);
    req = rand_req(32'h4426_fbbc);  // global y 4, x 9, word beef
    send_req(req, 1'b1, make_pkt(req, 4'd9, 3'd4, 28'h000_beef));
    req = rand_req(32'h2314_48d0);  // tile group 5+13 and 3+6 wrap to (2,1)
    send_req(req, 1'b1, make_pkt(req, 4'd2, 3'd1, 28'h000_1234));
    send_rand(32'h4000_0000, 32'h3fff_ffff, 10);
    send_rand(32'h2000_0000, 32'h1fff_ffff, 10);
    drain();
  endtask

  task automatic test_dram_hashed();
    test_name = "dram_hashed";
    set_config(1'b1, mdl_tgo_x, mdl_tgo_y);
    send_rand(32'h8000_0000, 32'h7fff_ffff, 50);
    drain();
  endtask

  task automatic test_dram_disabled();
    manycore_pkg::core_req_s req;
    test_name = "dram_disabled";
    set_config(1'b0, mdl_tgo_x, mdl_tgo_y);
    req = rand_req(32'h8000_3154);  // row bit set, x 2, word 55
    send_req(req, 1'b1, make_pkt(req, 4'd2, 3'd7, 28'h000_0055));
    req = rand_req(32'hc000_0010);
    send_req(req, 1'b1, make_pkt(req, 4'd0, 3'd0, 28'h800_0004));
    send_rand(32'hc000_0000, 32'h3fff_ffff, 6);  // host
    send_rand(32'h8000_0000, 32'h3fff_ffff, 6);  // direct mapped
    drain();
  endtask

  task automatic test_invalid();
    test_name = "invalid_addr";
    axil_write(manycore_pkg::csr_invalid_cnt_gp, 32'h0, 4'hf, okay_lp);
    axil_read_check(manycore_pkg::csr_invalid_cnt_gp, 32'h0, okay_lp);
    send_rand(32'h0000_0000, 32'h1fff_ffff, 3);
    send_rand(32'h4000_0000, 32'h3fff_ffff, 1);
    send_rand(32'h0000_0000, 32'h1fff_ffff, 2);
    drain();
    axil_read_check(manycore_pkg::csr_invalid_cnt_gp, 32'h5, okay_lp);
    axil_write(manycore_pkg::csr_invalid_cnt_gp, 32'h0, 4'hf, okay_lp);
    axil_read_check(manycore_pkg::csr_invalid_cnt_gp, 32'h0, okay_lp);
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    pkt_ready = 1'b0;
    fork
      send_rand(32'h4000_0000, 32'h3fff_ffff, 6);
      begin
        repeat (12) @(posedge clk);
        @(negedge clk);
        assert (!core_ready && pkt_v) else begin
          errors++;
          $display("backpressure: no packet held with core_ready low during the stall");
        end
        @(posedge clk);
        #1;
        pkt_ready = 1'b1;
      end
    join
    drain();
  endtask

  // scoreboard and hold check sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (held_v) begin
        assert (pkt === held_pkt) else begin
          errors++;
          $display("Mismatch in %s (held packet): expected %h, actual %h",
                   test_name, held_pkt, pkt);
        end
      end
      held_v   = pkt_v && !pkt_ready;
      held_pkt = pkt;
      if (pkt_v && pkt_ready) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("%s: packet %h sent with none expected", test_name, pkt);
        end
        if (exp_q.size() != 0) begin
          exp_pkt = exp_q.pop_front();
          pkt_checked++;
          assert (pkt === exp_pkt) else begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", test_name, exp_pkt, pkt);
          end
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < timeout_lp) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeout_lp);
    $display("Errors: %0d, packets checked: %0d", errors + 1, pkt_checked);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    errors      = 0;
    pkt_checked = 0;
    held_v      = 1'b0;
    lcg_state   = 32'd87;
    mdl_dram_en = 1'b0;
    mdl_tgo_x   = '0;
    mdl_tgo_y   = '0;
    test_name   = "reset";
    axil_req    = '0;
    core_req    = '0;
    core_v      = 1'b0;
    pkt_ready   = 1'b1;
    rst         = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("core_ready", 32'h1, 32'(core_ready));
    check_val("pkt_v", 32'h0, 32'(pkt_v));
    check_val("bvalid", 32'h0, 32'(axil_rsp.bvalid));
    check_val("rvalid", 32'h0, 32'(axil_rsp.rvalid));
    test_registers();
    test_remote();
    test_dram_hashed();
    test_dram_disabled();
    test_invalid();
    test_backpressure();
    $display("Errors: %0d, packets checked: %0d", errors, pkt_checked);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
manycore_pkg.sv
bank_hash.sv
eva_to_npa.sv
endpoint_cfg_regs.sv
remote_req_gen.sv
manycore_endpoint_top.sv
tb_clk_gen.sv
tb_manycore_endpoint.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_manycore_endpoint
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "result: FAIL"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
